/* hdl/dma_fifo_pkg.sv */
package dma_fifo_pkg;

  // Storage geometry
  localparam int fifo_depth = 8;   // Longword slots
  localparam int ptr_w      = 3;   // Next-in / next-out pointer width
  localparam int cnt_w      = 4;   // Occupancy count, holds 0..8
  localparam int data_w     = 32;  // Longword width
  localparam int lanes      = 4;   // Byte lanes per longword
  localparam int lane_w     = 8;   // Bits per lane

  // Lane numbering follows bit position, lane 3 is bits 31:24.
  // Big-endian bus order puts byte 0 there.
  localparam int lane_ll = 0;  // Bits 7:0
  localparam int lane_lm = 1;  // Bits 15:8
  localparam int lane_um = 2;  // Bits 23:16
  localparam int lane_uu = 3;  // Bits 31:24

  // Load opcodes from the CPU and SCSI sequencers
  typedef enum logic [2:0] {
    fifo_load_none  = 3'd0,  // No write this cycle
    fifo_load_lword = 3'd1,  // Low word, bits 15:0
    fifo_load_hword = 3'd2,  // High word, bits 31:16
    fifo_load_long  = 3'd3,  // All four lanes
    fifo_load_byte  = 3'd4   // Single lane picked by byte pointer
  } fifo_load_op_e;

  // Byte pointer
  // 0 addresses the first byte on the bus, bits 31:24
  // 3 addresses the fourth byte, bits 7:0
  typedef logic [1:0] byte_ptr_t;

endpackage

/* hdl/fifo_lane_strobes.sv */
module fifo_lane_strobes
  import dma_fifo_pkg::*;
(
  input  fifo_load_op_e     load_op,  // Load request this cycle
  input  byte_ptr_t         ptr,      // Current byte pointer
  output logic [lanes-1:0]  lane_we   // Per-lane write enables to the buffer
);

  // Byte pointer to lane, big-endian: byte 0 sits in the top lane
  logic [lanes-1:0] byte_lane;

  always_comb begin
    byte_lane = '0;
    case (ptr)
      2'd0: byte_lane[lane_uu] = 1'b1;  // First byte, 31:24
      2'd1: byte_lane[lane_um] = 1'b1;
      2'd2: byte_lane[lane_lm] = 1'b1;
      default: byte_lane[lane_ll] = 1'b1;  // Fourth byte, 7:0
    endcase
  end

  // Opcode decode into lane enables
  always_comb begin
    lane_we = '0;
    unique case (load_op)
      fifo_load_lword: begin
        lane_we[lane_lm] = 1'b1;  // Low word only
        lane_we[lane_ll] = 1'b1;
      end
      fifo_load_hword: begin
        lane_we[lane_uu] = 1'b1;  // High word only
        lane_we[lane_um] = 1'b1;
      end
      fifo_load_long: lane_we = '1;  // Whole longword
      fifo_load_byte: lane_we = byte_lane;  // SCSI side, one byte per strobe
      default: lane_we = '0;  // fifo_load_none
    endcase
  end

  // A byte load must never touch more than one lane, or the
  // SCSI side would smear one byte across the longword
  always_comb begin
    if (load_op == fifo_load_byte) begin
      a_byte_onehot : assert final ($onehot(lane_we))
        else $error("byte load lane_we not one-hot: %b", lane_we);
    end
  end

endmodule

/* hdl/fifo_occupancy.sv */
module fifo_occupancy
  import dma_fifo_pkg::*;
(
  input  logic llws,
  input  logic rst,
  input  logic fifo_clr,  // Synchronous FIFO clear
  input  logic inc_fifo,  // One more longword held
  input  logic dec_fifo,  // One longword taken
  output logic full,
  output logic empty
);

  logic [cnt_w-1:0] count;     // Longwords held in 0..fifo_depth
  logic [cnt_w-1:0] count_nxt;
  logic             do_inc;
  logic             do_dec;

  // Both strobes together cancel out
  // A violating strobe is dropped so the count saturates
  assign do_inc = inc_fifo && !dec_fifo && (count != cnt_w'(fifo_depth));
  assign do_dec = dec_fifo && !inc_fifo && (count != '0);

  always_comb begin
    count_nxt = count;
    if (do_inc) count_nxt = count + 1'b1;
    else if (do_dec) count_nxt = count - 1'b1;
  end

  // Flags are registered from the next count on the same edge as the count
  always_ff @(posedge llws) begin
    if (rst || fifo_clr) begin
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;  // Nothing held after clear
    end else begin
      count <= count_nxt;
      full  <= (count_nxt == cnt_w'(fifo_depth));
      empty <= (count_nxt == '0);
    end
  end

  // Sequencers must not push into a full FIFO without a matching pop
  a_inc_when_full : assert property (
    @(posedge llws) disable iff (rst || fifo_clr)
    !(inc_fifo && !dec_fifo && full))
    else $error("inc_fifo while full");

  // Nor pop from an empty one
  a_dec_when_empty : assert property (
    @(posedge llws) disable iff (rst || fifo_clr)
    !(dec_fifo && !inc_fifo && empty))
    else $error("dec_fifo while empty");

endmodule

/* hdl/fifo_byte_ptr.sv */
module fifo_byte_ptr
  import dma_fifo_pkg::*;
(
  input  logic      llws,
  input  logic      rst,
  input  logic      fifo_clr,  // Synchronous FIFO clear
  input  logic      inc_bo,    // Step to next byte from the SCSI sequencer
  input  logic      acr_wr,    // Register write strobe
  input  logic      h_0c,      // Address decode for the ACR
  input  logic      mid25,     // ACR bit that seeds the pointer MSB
  output byte_ptr_t ptr
);

  logic acr_load;  // Preload from the ACR this cycle

  assign acr_load = acr_wr && h_0c;

  // Clear wins over ACR preload, which wins over increment
  always_ff @(posedge llws) begin
    if (rst || fifo_clr) begin
      ptr <= '0;  // Back to first byte
    end else if (acr_load) begin
      // Transfer starts on a word boundary so only bit 1 is taken
      ptr <= {mid25, 1'b0};
    end else if (inc_bo) begin
      ptr <= ptr + 2'd1;  // Wraps 3 -> 0 on its own
    end
  end

  // When preload and increment collide, the preload value must win
  a_preload_wins : assert property (
    @(posedge llws) disable iff (rst || fifo_clr)
    (acr_load && inc_bo) |=> (ptr == {$past(mid25), 1'b0}))
    else $error("ACR preload lost to inc_bo, ptr=%0d", ptr);

endmodule

/* hdl/fifo_buffer.sv */
module fifo_buffer
  import dma_fifo_pkg::*;
(
  input  logic              llws,
  input  logic              rst,
  input  logic              fifo_clr,  // Synchronous FIFO clear
  input  logic [lanes-1:0]  lane_we,   // Byte lane enables from the decode
  input  logic [data_w-1:0] id,        // Write data in bus order
  input  logic              inc_ni,    // Advance next-in after this write
  input  logic              inc_no,    // Advance next-out
  output logic [data_w-1:0] od         // Longword under next-out
);

  // 8 x 32 longword storage
  logic [data_w-1:0] mem [fifo_depth];

  logic [ptr_w-1:0] next_in;   // Write slot
  logic [ptr_w-1:0] next_out;  // Read slot

  // Pointer counters
  // Wrap modulo 8 falls out of the 3-bit width
  always_ff @(posedge llws) begin
    if (rst || fifo_clr) begin
      next_in  <= '0;
      next_out <= '0;
    end else begin
      if (inc_ni) next_in <= next_in + 1'b1;
      if (inc_no) next_out <= next_out + 1'b1;
    end
  end

  // Lane-masked write into the slot under next-in
  // A write together with inc_ni lands in the old slot
  always_ff @(posedge llws) begin
    for (int l = 0; l < lanes; l++) begin
      if (lane_we[l]) begin
        mem[next_in][l*lane_w +: lane_w] <= id[l*lane_w +: lane_w];
      end
    end
  end

  // Asynchronous read shows a write the cycle after the strobe
  assign od = mem[next_out];

  // Write data must be known on every enabled lane
  a_wdata_known : assert property (
    @(posedge llws) disable iff (rst)
    (lane_we != '0) |-> !$isunknown(id & {
      {lane_w{lane_we[lane_uu]}}, {lane_w{lane_we[lane_um]}},
      {lane_w{lane_we[lane_lm]}}, {lane_w{lane_we[lane_ll]}}}))
    else $error("unknown write data on an enabled lane");

endmodule

/* hdl/dma_fifo_top.sv */
module dma_fifo_top
  import dma_fifo_pkg::*;
(
  input  logic              llws,
  input  logic              rst,
  input  logic              fifo_clr,  // Synchronous FIFO clear
  input  fifo_load_op_e     load_op,   // Load request
  input  logic [data_w-1:0] id,        // FIFO data in
  input  logic              inc_ni,    // Next-in strobe
  input  logic              inc_no,    // Next-out strobe
  input  logic              inc_fifo,  // Occupancy up
  input  logic              dec_fifo,  // Occupancy down
  input  logic              inc_bo,    // Byte pointer step, SCSI side
  input  logic              acr_wr,    // Register write strobe
  input  logic              h_0c,      // ACR address decode
  input  logic              mid25,     // ACR seed for byte pointer
  output logic [data_w-1:0] od,        // FIFO data out
  output logic              full,
  output logic              empty,
  output logic              bo0,       // Byte pointer bit 0
  output logic              bo1,       // Byte pointer bit 1
  output logic              boeq0,     // Pointer on first byte
  output logic              boeq3      // Pointer on fourth byte
);

  byte_ptr_t        ptr;      // Byte pointer, shared by decode and status
  logic [lanes-1:0] lane_we;  // Lane enables into storage

  // Opcode and byte pointer to lane enables
  fifo_lane_strobes u_lane_strobes (
    .load_op (load_op),
    .ptr     (ptr),
    .lane_we (lane_we)
  );

  // Full / empty tracking
  fifo_occupancy u_occupancy (
    .llws     (llws),
    .rst      (rst),
    .fifo_clr (fifo_clr),
    .inc_fifo (inc_fifo),
    .dec_fifo (dec_fifo),
    .full     (full),
    .empty    (empty)
  );

  fifo_byte_ptr u_byte_ptr (
    .llws     (llws),
    .rst      (rst),
    .fifo_clr (fifo_clr),
    .inc_bo   (inc_bo),
    .acr_wr   (acr_wr),
    .h_0c     (h_0c),
    .mid25    (mid25),
    .ptr      (ptr)
  );

  // Storage with its next-in / next-out counters
  fifo_buffer u_buffer (
    .llws     (llws),
    .rst      (rst),
    .fifo_clr (fifo_clr),
    .lane_we  (lane_we),
    .id       (id),
    .inc_ni   (inc_ni),
    .inc_no   (inc_no),
    .od       (od)
  );

  // Pointer status back to the SCSI sequencer
  assign bo0   = ptr[0];
  assign bo1   = ptr[1];
  assign boeq0 = (ptr == 2'd0);
  assign boeq3 = (ptr == 2'd3);  // Last byte of the longword

endmodule

/* dv/tb_dma_fifo.sv */
module tb_dma_fifo
  import dma_fifo_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  logic              llws;
  logic              rst;
  logic              fifo_clr;
  fifo_load_op_e     load_op;
  logic [data_w-1:0] id;
  logic              inc_ni, inc_no, inc_fifo, dec_fifo;
  logic              inc_bo, acr_wr, h_0c, mid25;
  logic [data_w-1:0] od;
  logic              full, empty, bo0, bo1, boeq0, boeq3;

  int gold_errs;   // Mismatches in the directed vectors
  int rand_errs;   // Mismatches in the random phase
  int other_errs;  // Timeouts, file trouble
  int vec_cnt;     // Directed vectors applied
  logic [31:0] seed;
  logic [data_w-1:0] model[$];  // Reference FIFO contents, head is next out

  dma_fifo_top DUT (
    .llws(llws), .rst(rst), .fifo_clr(fifo_clr), .load_op(load_op), .id(id),
    .inc_ni(inc_ni), .inc_no(inc_no), .inc_fifo(inc_fifo), .dec_fifo(dec_fifo),
    .inc_bo(inc_bo), .acr_wr(acr_wr), .h_0c(h_0c), .mid25(mid25),
    .od(od), .full(full), .empty(empty),
    .bo0(bo0), .bo1(bo1), .boeq0(boeq0), .boeq3(boeq3)
  );

  initial begin
    llws = 1'b0;
    forever #5 llws = ~llws;  // 10 ns period
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v ^= v << 13;
    v ^= v >> 17;
    v ^= v << 5;
    return v;
  endfunction

  // All strobes low, no load
  task automatic idle_inputs();
    fifo_clr = 1'b0;
    load_op  = fifo_load_none;
    id       = '0;
    inc_ni   = 1'b0;
    inc_no   = 1'b0;
    inc_fifo = 1'b0;
    dec_fifo = 1'b0;
    inc_bo   = 1'b0;
    acr_wr   = 1'b0;
    h_0c     = 1'b0;
    mid25    = 1'b0;
  endtask

  // One clock, then back to idle 1 ns after the edge
  task automatic next_cycle();
    @(posedge llws);
    #1;
    idle_inputs();
  endtask

  task automatic count_error(input bit random_phase);
    if (random_phase) rand_errs++;
    else gold_errs++;
  endtask

  // Compare DUT outputs against expectations, ptr status from the pointer value
  task automatic check_outputs(input string name, input logic [data_w-1:0] exp_od,
                               input bit chk_od, input logic exp_full,
                               input logic exp_empty, input logic [1:0] exp_ptr,
                               input bit random_phase);
    if (chk_od) begin
      assert (od === exp_od) else begin
        count_error(random_phase);
        $display("Error: %0s od expected %h actual %h", name, exp_od, od);
      end
    end
    assert (full === exp_full) else begin
      count_error(random_phase);
      $display("Error: %0s full expected %b actual %b", name, exp_full, full);
    end
    assert (empty === exp_empty) else begin
      count_error(random_phase);
      $display("Error: %0s empty expected %b actual %b", name, exp_empty, empty);
    end
    assert ({bo1, bo0} === exp_ptr) else begin
      count_error(random_phase);
      $display("Error: %0s ptr expected %0d actual %0d", name, exp_ptr, {bo1, bo0});
    end
    assert (boeq0 === (exp_ptr == 2'd0) && boeq3 === (exp_ptr == 2'd3)) else begin
      count_error(random_phase);
      $display("Error: %0s boeq0/boeq3 expected %b%b actual %b%b", name,
               exp_ptr == 2'd0, exp_ptr == 2'd3, boeq0, boeq3);
    end
  endtask

  // Bounded wait for the empty flag
  task automatic wait_for_empty(input string why);
    int t;
    t = 0;
    while (empty !== 1'b1 && t < 20) begin
      next_cycle();
      t++;
    end
    if (empty !== 1'b1) begin
      other_errs++;
      $display("Timed out waiting for the FIFO to report empty after %0s", why);
    end
  endtask

  // Directed vectors, one per cycle, checked after the following edge
  task automatic run_golden();
    int fh, n, op, ep, lines_read;
    string line, name;
    logic [data_w-1:0] vid, eod;
    bit ni, no, fi, df, bo, acr, h0, m25, clr, ef, ee;
    fh = $fopen("dv/dma_fifo_golden.txt", "r");
    if (fh == 0) begin
      other_errs++;
      $display("Could not open the golden vector file");
      return;
    end
    lines_read = 0;
    while (!$feof(fh) && lines_read < 1000) begin  // Line cap guards a bad file
      line = "";
      n = $fgets(line, fh);
      lines_read++;
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;  // Blank or comment
      n = $sscanf(line, "%s %d %h %b %b %b %b %b %b %b %b %b %h %b %b %d",
                  name, op, vid, ni, no, fi, df, bo, acr, h0, m25, clr, eod, ef, ee, ep);
      if (n != 16) begin
        other_errs++;
        $display("Golden line could not be parsed: %0s", line);
        continue;
      end
      load_op  = fifo_load_op_e'(op);
      id       = vid;
      inc_ni   = ni;
      inc_no   = no;
      inc_fifo = fi;
      dec_fifo = df;
      inc_bo   = bo;
      acr_wr   = acr;
      h_0c     = h0;
      mid25    = m25;
      fifo_clr = clr;
      next_cycle();  // Result visible one cycle on
      check_outputs(name, eod, 1'b1, ef, ee, ep[1:0], 1'b0);
      vec_cnt++;
    end
    $fclose(fh);
    if (vec_cnt == 0) begin
      other_errs++;
      $display("No directed vectors were found in the golden file");
    end
  endtask

  // Random fill and drain against the queue model
  task automatic run_random();
    logic [data_w-1:0] data;
    bit                push;
    fifo_clr = 1'b1;  // Start from a known empty FIFO
    next_cycle();
    wait_for_empty("clear");
    model.delete();
    for (int step = 0; step < 300; step++) begin
      seed = xorshift32(seed);
      push = seed[0];
      if (push && model.size() < fifo_depth) begin
        seed = xorshift32(seed);
        data = seed;
        load_op  = fifo_load_long;
        id       = data;
        inc_ni   = 1'b1;
        inc_fifo = 1'b1;
        model.push_back(data);
      end else if (!push && model.size() > 0) begin
        // Head must be on od before it is popped
        check_outputs($sformatf("rand_pop_%0d", step), model[0], 1'b1,
                      model.size() == fifo_depth, 1'b0, 2'd0, 1'b1);
        inc_no   = 1'b1;
        dec_fifo = 1'b1;
        void'(model.pop_front());
      end
      next_cycle();
      check_outputs($sformatf("rand_step_%0d", step),
                    (model.size() > 0) ? model[0] : '0, model.size() > 0,
                    model.size() == fifo_depth, model.size() == 0, 2'd0, 1'b1);
    end
  endtask

  initial begin
    gold_errs  = 0;
    rand_errs  = 0;
    other_errs = 0;
    vec_cnt    = 0;
    seed       = 32'h22d75961;
    idle_inputs();
    rst = 1'b1;
    repeat (2) @(posedge llws);
    #1;
    rst = 1'b0;
    wait_for_empty("reset");
    run_golden();
    run_random();
    $display("Errors: golden %0d, random %0d, other %0d (%0d directed vectors)",
             gold_errs, rand_errs, other_errs, vec_cnt);
    if (gold_errs + rand_errs + other_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* dv/dma_fifo_golden.txt */
# name op id inc_ni inc_no inc_fifo dec_fifo inc_bo acr_wr h_0c mid25 fifo_clr od full empty ptr
# op: 0 none 1 lword 2 hword 3 long 4 byte; id and od hex, ptr decimal, the rest single bits
push0 3 01234567 1 0 1 0 0 0 0 0 0 01234567 0 0 0
push1 3 89abcdef 1 0 1 0 0 0 0 0 0 01234567 0 0 0
push2 3 deadbeef 1 0 1 0 0 0 0 0 0 01234567 0 0 0
push3 3 cafef00d 1 0 1 0 0 0 0 0 0 01234567 0 0 0
push4 3 0badc0de 1 0 1 0 0 0 0 0 0 01234567 0 0 0
push5 3 12345678 1 0 1 0 0 0 0 0 0 01234567 0 0 0
push6 3 87654321 1 0 1 0 0 0 0 0 0 01234567 0 0 0
push7 3 55aa33cc 1 0 1 0 0 0 0 0 0 01234567 1 0 0
pop0 0 00000000 0 1 0 1 0 0 0 0 0 89abcdef 0 0 0
pop1 0 00000000 0 1 0 1 0 0 0 0 0 deadbeef 0 0 0
pop2 0 00000000 0 1 0 1 0 0 0 0 0 cafef00d 0 0 0
pop3 0 00000000 0 1 0 1 0 0 0 0 0 0badc0de 0 0 0
pop4 0 00000000 0 1 0 1 0 0 0 0 0 12345678 0 0 0
pop5 0 00000000 0 1 0 1 0 0 0 0 0 87654321 0 0 0
pop6 0 00000000 0 1 0 1 0 0 0 0 0 55aa33cc 0 0 0
pop7 0 00000000 0 1 0 1 0 0 0 0 0 01234567 0 1 0
lword 1 ffff2222 0 0 0 0 0 0 0 0 0 01232222 0 1 0
hword 2 3333eeee 1 0 1 0 0 0 0 0 0 33332222 0 0 0
pop_lh 0 00000000 0 1 0 1 0 0 0 0 0 89abcdef 0 1 0
byte0 4 a1b1c1d1 0 0 0 0 1 0 0 0 0 a1abcdef 0 1 1
byte1 4 a2b2c2d2 0 0 0 0 1 0 0 0 0 a1b2cdef 0 1 2
byte2 4 a3b3c3d3 0 0 0 0 1 0 0 0 0 a1b2c3ef 0 1 3
byte3 4 a4b4c4d4 1 0 1 0 1 0 0 0 0 a1b2c3d4 0 0 0
pop_b 0 00000000 0 1 0 1 0 0 0 0 0 deadbeef 0 1 0
acr 0 00000000 0 0 0 0 1 1 1 1 0 deadbeef 0 1 2
byte_acr 4 99887766 1 0 1 0 1 0 0 0 0 dead77ef 0 0 3
clr 0 00000000 0 0 0 0 0 0 0 0 1 33332222 0 1 0
push_clr 3 600dcafe 1 0 1 0 0 0 0 0 0 600dcafe 0 0 0
pop_clr 0 00000000 0 1 0 1 0 0 0 0 0 a1b2c3d4 0 1 0

/* dma_fifo_top.f */
hdl/dma_fifo_pkg.sv
hdl/fifo_lane_strobes.sv
hdl/fifo_occupancy.sv
hdl/fifo_byte_ptr.sv
hdl/fifo_buffer.sv
hdl/dma_fifo_top.sv
dv/tb_dma_fifo.sv
